// File: Makefile
# Verilator build and run of the multiplier testbench

TOP = mul_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

obj_dir/V$(TOP): files.f $(wildcard rtl/*.sv) $(wildcard test/*.sv)
	verilator --binary --timing --assert --top-module $(TOP) \
		-f files.f -Mdir obj_dir -o V$(TOP)

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failures found" $(LOG) || ! grep -q "All tests passed!" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; \
		exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: files.f
rtl/mul_pkg.sv
rtl/ripple_carry_adder.sv
rtl/mul_operand_shift.sv
rtl/mul_accum.sv
rtl/mul_ctrl.sv
rtl/mul_top.sv
test/mul_asserts.sv
test/mul_tb.sv

// File: rtl/mul_accum.sv
module mul_accum #(
	parameter int PROD_BITS = 16
) (
	input  logic                 in_clk,
	input  logic                 in_rst,
	input  mul_pkg::mul_ctl_t    ctl,
	input  logic [PROD_BITS-1:0] b_shifted,
	output logic [PROD_BITS-1:0] prod
);

	// running product plus the shifted multiplicand
	logic [PROD_BITS-1:0] sum;

	// adder from full-adder cells, wraps at the product width
	ripple_carry_adder #(
		.BITS (PROD_BITS)
	) u_adder (
		.in_a (prod),
		.in_b (b_shifted),
		.sum  (sum)
	);

	// product register
	// clear on load, accumulate on add, hold otherwise
	// held value is the result seen after done
	always_ff @(posedge in_clk, posedge in_rst) begin
		if (in_rst) begin
			prod <= '0;
		end else if (ctl.load) begin
			prod <= '0; // fresh product for new operands
		end else if (ctl.add) begin
			prod <= sum; // multiplier bit was set
		end
	end

endmodule

// File: rtl/mul_ctrl.sv
module mul_ctrl #(
	parameter int OPD_BITS = 8
) (
	input  logic              in_clk,
	input  logic              in_rst,
	input  logic              in_start,
	input  logic              a_lsb,
	output mul_pkg::mul_ctl_t ctl,
	output logic              out_done
);

	// one spare bit over the bit index range
	localparam int CNT_BITS = $clog2(OPD_BITS) + 1;

	// index of the final multiplier bit
	localparam logic [CNT_BITS-1:0] LAST_BIT = CNT_BITS'(OPD_BITS - 1);

	mul_pkg::mul_state_t state;      // current state
	mul_pkg::mul_state_t state_next; // next state

	logic [CNT_BITS-1:0] bit_cnt;      // multiplier bit under test
	logic [CNT_BITS-1:0] bit_cnt_next;

	logic start_ok; // start accepted, only in idle
	logic last_bit; // working on the top multiplier bit

	assign start_ok = in_start && (state == mul_pkg::ST_IDLE);
	assign last_bit = (bit_cnt == LAST_BIT);

	// state and bit counter registers
	always_ff @(posedge in_clk, posedge in_rst) begin
		if (in_rst) begin
			state   <= mul_pkg::ST_IDLE;
			bit_cnt <= '0;
		end else begin
			state   <= state_next;
			bit_cnt <= bit_cnt_next;
		end
	end

	// next state and counter
	always_comb begin
		state_next   = state;   // hold by default
		bit_cnt_next = bit_cnt;

		unique case (state)
			mul_pkg::ST_IDLE: begin
				// a start while busy never gets here, so it is dropped
				if (start_ok) begin
					state_next   = mul_pkg::ST_CHECK;
					bit_cnt_next = '0; // begin at bit 0
				end
			end

			mul_pkg::ST_CHECK: begin
				// set bit needs an add cycle first
				if (a_lsb) begin
					state_next = mul_pkg::ST_ADD;
				end else begin
					state_next = mul_pkg::ST_NEXT;
				end
			end

			mul_pkg::ST_ADD: begin
				state_next = mul_pkg::ST_NEXT; // product updates this edge
			end

			mul_pkg::ST_NEXT: begin
				if (last_bit) begin
					state_next = mul_pkg::ST_DONE; // all bits walked
				end else begin
					state_next   = mul_pkg::ST_CHECK;
					bit_cnt_next = bit_cnt + 1'b1;
				end
			end

			mul_pkg::ST_DONE: begin
				state_next = mul_pkg::ST_IDLE; // done for one cycle only
			end

			default: begin
				state_next = mul_pkg::ST_IDLE; // recover from a bad encoding
			end
		endcase
	end

	// strobes decoded from the state
	// load is immediate, datapath acts on the closing edge
	assign ctl.load  = start_ok;
	assign ctl.add   = (state == mul_pkg::ST_ADD);
	assign ctl.shift = (state == mul_pkg::ST_NEXT);

	// product valid in this cycle
	assign out_done = (state == mul_pkg::ST_DONE);

endmodule

// File: rtl/mul_operand_shift.sv
module mul_operand_shift #(
	parameter int OPD_BITS  = 8,
	parameter int PROD_BITS = 16
) (
	input  logic                 in_clk,
	input  logic                 in_rst,
	input  mul_pkg::mul_ctl_t    ctl,
	input  logic [OPD_BITS-1:0]  in_a,
	input  logic [OPD_BITS-1:0]  in_b,
	output logic                 a_lsb,
	output logic [PROD_BITS-1:0] b_shifted
);

	// multiplier, walked LSB first
	logic [OPD_BITS-1:0]  a_reg;

	// multiplicand, kept aligned with the current multiplier bit
	logic [PROD_BITS-1:0] b_reg;

	// multiplier register
	// shifts right so bit 0 is always the bit under test
	always_ff @(posedge in_clk, posedge in_rst) begin
		if (in_rst) begin
			a_reg <= '0;
		end else if (ctl.load) begin
			a_reg <= in_a; // new operand
		end else if (ctl.shift) begin
			a_reg <= a_reg >> 1; // next bit into lsb
		end
	end

	// multiplicand register
	// one place left per bit step, matches the weight of a_lsb
	always_ff @(posedge in_clk, posedge in_rst) begin
		if (in_rst) begin
			b_reg <= '0;
		end else if (ctl.load) begin
			b_reg <= PROD_BITS'(in_b); // zero extend to product width
		end else if (ctl.shift) begin
			b_reg <= b_reg << 1; // bits past PROD_BITS drop off
		end
	end

	// current multiplier bit back to the FSM
	assign a_lsb = a_reg[0];

	// weighted multiplicand to the accumulator
	assign b_shifted = b_reg;

endmodule

// File: rtl/mul_pkg.sv
package mul_pkg;

	// default operand width, multiplier and multiplicand
	localparam int OPD_BITS_DEF  = 8;

	// default product width
	// a narrower product than 2*OPD_BITS truncates
	localparam int PROD_BITS_DEF = 16;

	// control strobes from the FSM to the datapath
	typedef struct packed {
		logic load;  // capture operands, clear product
		logic shift; // advance to the next multiplier bit
		logic add;   // accumulate the shifted multiplicand
	} mul_ctl_t;

	// controller states
	// one bit step is CHECK, optional ADD, then NEXT
	typedef enum logic [2:0] {
		ST_IDLE  = 3'd0, // wait for start
		ST_CHECK = 3'd1, // look at current multiplier bit
		ST_ADD   = 3'd2, // bit set, add shifted multiplicand
		ST_NEXT  = 3'd3, // shift operands, count the bit
		ST_DONE  = 3'd4  // product ready, done strobe
	} mul_state_t;

endpackage

// File: rtl/mul_top.sv
module mul_top #(
	parameter int OPD_BITS  = mul_pkg::OPD_BITS_DEF,
	parameter int PROD_BITS = mul_pkg::PROD_BITS_DEF
) (
	input  logic                 in_clk,
	input  logic                 in_rst,
	input  logic                 in_start,
	input  logic [OPD_BITS-1:0]  in_a,
	input  logic [OPD_BITS-1:0]  in_b,
	output logic [PROD_BITS-1:0] out_prod,
	output logic                 out_done
);

	mul_pkg::mul_ctl_t    ctl;       // strobes from the FSM
	logic                 a_lsb;     // multiplier bit under test
	logic [PROD_BITS-1:0] b_shifted; // weighted multiplicand

	// sequencer for the bit steps
	mul_ctrl #(
		.OPD_BITS (OPD_BITS)
	) u_ctrl (
		.in_clk   (in_clk),
		.in_rst   (in_rst),
		.in_start (in_start),
		.a_lsb    (a_lsb),
		.ctl      (ctl),
		.out_done (out_done)
	);

	// operand registers, one place shift per step
	mul_operand_shift #(
		.OPD_BITS  (OPD_BITS),
		.PROD_BITS (PROD_BITS)
	) u_opd (
		.in_clk    (in_clk),
		.in_rst    (in_rst),
		.ctl       (ctl),
		.in_a      (in_a),
		.in_b      (in_b),
		.a_lsb     (a_lsb),
		.b_shifted (b_shifted)
	);

	// running product, also the result output
	mul_accum #(
		.PROD_BITS (PROD_BITS)
	) u_accum (
		.in_clk    (in_clk),
		.in_rst    (in_rst),
		.ctl       (ctl),
		.b_shifted (b_shifted),
		.prod      (out_prod)
	);

endmodule

// File: rtl/ripple_carry_adder.sv
module ripple_carry_adder #(
	parameter int BITS = 16
) (
	input  logic [BITS-1:0] in_a,
	input  logic [BITS-1:0] in_b,
	output logic [BITS-1:0] sum
);

	// carry into each bit position
	// no carry out of the top cell, result wraps modulo 2**BITS
	logic [BITS-1:0] carry;

	assign carry[0] = 1'b0; // nothing carried into bit 0

	// one full-adder cell per bit
	for (genvar i = 0; i < BITS; i++) begin : g_cell
		// sum bit of the cell
		assign sum[i] = in_a[i] ^ in_b[i] ^ carry[i];

		// carry out ripples into the next cell
		if (i < BITS - 1) begin : g_carry
			assign carry[i+1] = (in_a[i] & in_b[i]) |
				(in_a[i] & carry[i]) | // generate or propagate
				(in_b[i] & carry[i]);
		end
	end

endmodule

// File: test/mul_asserts.sv
module mul_asserts (
	input logic                in_clk,
	input logic                in_rst,
	input logic                a_lsb,
	input mul_pkg::mul_state_t state,
	input mul_pkg::mul_ctl_t   ctl,
	input logic                out_done
);

	// done is a strobe, low again on the next edge
	done_one_cycle: assert property (
		@(posedge in_clk) disable iff (in_rst)
		out_done |=> !out_done
	) else $error("out_done high for more than one cycle");

	// accumulate only from the add state
	// reached from a check cycle that saw a set multiplier bit
	add_in_add_state: assert property (
		@(posedge in_clk) disable iff (in_rst)
		ctl.add |-> $past((state == mul_pkg::ST_CHECK) && a_lsb)
	) else $error("add strobe without a set multiplier bit");

	// nothing moves while reset is held
	quiet_in_reset: assert property (
		@(posedge in_clk)
		in_rst |-> ((ctl == '0) && !out_done)
	) else $error("strobe active during reset");

	// busy, so a start must not reload
	// a load only ever follows an idle or done cycle
	no_load_when_busy: assert property (
		@(posedge in_clk) disable iff (in_rst)
		ctl.load |-> ($past(state) inside {mul_pkg::ST_IDLE, mul_pkg::ST_DONE})
	) else $error("load issued while a product was in flight");

endmodule

bind mul_ctrl mul_asserts u_asserts (
	.in_clk   (in_clk),
	.in_rst   (in_rst),
	.a_lsb    (a_lsb),
	.state    (state),
	.ctl      (ctl),
	.out_done (out_done)
);

// File: test/mul_tb.sv
module mul_tb;

	localparam int OPD_BITS  = mul_pkg::OPD_BITS_DEF;
	localparam int PROD_BITS = mul_pkg::PROD_BITS_DEF;

	localparam int CLK_PERIOD = 20;
	localparam int RST_CYCLES = 10;
	localparam int DRIVE_DLY  = 2; // inputs change this long after the edge
	localparam int SAMPLE_DLY = 1; // outputs read here, settled after the edge
	localparam int SEED       = 42;

	localparam int N_FIXED     = 8;
	localparam int N_RAND      = 12;
	localparam int N_VEC       = N_FIXED + N_RAND;
	localparam int HOLD_CYCLES = 3;              // idle cycles checked after done
	localparam int MAX_WAIT    = 3 * OPD_BITS + 4; // per product, worst case is 24

	// whole run, worst case per product plus reset and idle checks
	localparam int WATCHDOG_CYCLES = N_VEC * (3 * OPD_BITS + 4) + 20;

	// one stimulus line with its expected results
	typedef struct packed {
		logic [OPD_BITS-1:0]  a;
		logic [OPD_BITS-1:0]  b;
		int                   poke;     // cycle of a stray start, 0 for none
		logic [PROD_BITS-1:0] exp_prod;
		int                   exp_lat;  // edges from start to done
	} vec_t;

	logic                 in_clk = 1'b0;
	logic                 in_rst;
	logic                 in_start;
	logic [OPD_BITS-1:0]  in_a;
	logic [OPD_BITS-1:0]  in_b;
	logic [PROD_BITS-1:0] out_prod;
	logic                 out_done;

	vec_t vec_tab[$];
	int   err_cnt = 0;

	mul_top #(
		.OPD_BITS  (OPD_BITS),
		.PROD_BITS (PROD_BITS)
	) u_dut (
		.in_clk   (in_clk),
		.in_rst   (in_rst),
		.in_start (in_start),
		.in_a     (in_a),
		.in_b     (in_b),
		.out_prod (out_prod),
		.out_done (out_done)
	);

	always #(CLK_PERIOD / 2) in_clk = ~in_clk;

	// reference product, wraps at the product width
	function automatic logic [PROD_BITS-1:0] ref_product(input logic [OPD_BITS-1:0] a,
			input logic [OPD_BITS-1:0] b);
		longint full;
		full = longint'(a) * longint'(b);
		return PROD_BITS'(full);
	endfunction

	function automatic int count_ones(input logic [OPD_BITS-1:0] v);
		int n;
		n = 0;
		for (int i = 0; i < OPD_BITS; i++) begin
			if (v[i]) n++;
		end
		return n;
	endfunction

	function automatic void add_vec(input logic [OPD_BITS-1:0] a, input logic [OPD_BITS-1:0] b,
			input int poke);
		vec_t v;
		v.a        = a;
		v.b        = b;
		v.poke     = poke;
		v.exp_prod = ref_product(a, b);
		v.exp_lat  = 2 * OPD_BITS + count_ones(a); // check + next per bit, add per set bit
		vec_tab.push_back(v);
	endfunction

	function automatic void build_table();
		add_vec(8'd0, 8'd0, 0);
		add_vec(8'd0, 8'd255, 0);   // zero multiplier, no add cycles
		add_vec(8'd255, 8'd0, 0);   // all ones, longest run
		add_vec(8'd1, 8'd1, 0);
		add_vec(8'd255, 8'd255, 0);
		add_vec(8'd170, 8'd85, 5);  // stray start early on
		add_vec(8'd85, 8'd170, 0);
		add_vec(8'd128, 8'd2, 10);  // stray start near the end
		for (int i = 0; i < N_RAND; i++) begin
			add_vec(OPD_BITS'($urandom), OPD_BITS'($urandom), (i == 3) ? 7 : 0);
		end
	endfunction

	task automatic abort_run();
		err_cnt++;
		$display("Test failures found");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_prod(input logic [PROD_BITS-1:0] got, input logic [PROD_BITS-1:0] want,
			input string name);
		if (got !== want) begin
			$display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, want);
			abort_run();
		end
	endtask

	task automatic check_done(input logic got, input logic want, input string name);
		if (got !== want) begin
			$display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, want);
			abort_run();
		end
	endtask

	task automatic check_latency(input int got, input int want, input string name);
		if (got != want) begin
			$display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, want);
			abort_run();
		end
	endtask

	// one product: start strobe, wait for done, report result and edge count
	task automatic run_vec(input vec_t v, output logic [PROD_BITS-1:0] prod_seen,
			output int lat_seen);
		int cyc;
		bit seen;
		@(posedge in_clk);
		#DRIVE_DLY;
		in_start = 1'b1;
		in_a     = v.a;
		in_b     = v.b;
		@(posedge in_clk); // start sampled on this edge
		#SAMPLE_DLY;
		cyc  = 0;
		seen = 1'b0;
		while (!seen && cyc < MAX_WAIT) begin
			#(DRIVE_DLY - SAMPLE_DLY);
			if (v.poke != 0 && cyc == v.poke) begin
				in_start = 1'b1; // busy, must be dropped
				in_a     = ~v.a;
				in_b     = ~v.b;
			end else begin
				in_start = 1'b0;
				in_a     = ~v.a; // operands were captured, junk here
			end
			@(posedge in_clk);
			#SAMPLE_DLY;
			cyc++;
			if (out_done) seen = 1'b1;
		end
		if (!seen) begin
			$display("ERROR: out_done never came within %0d cycles for a=%0d b=%0d",
				MAX_WAIT, v.a, v.b);
			abort_run();
		end
		prod_seen = out_prod;
		lat_seen  = cyc;
	endtask

	// watchdog, whole run bounded
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("ERROR: watchdog expired after %0d clock periods", WATCHDOG_CYCLES);
		abort_run();
	end

	initial begin
		vec_t                 v;
		logic [PROD_BITS-1:0] prod_seen;
		int                   lat_seen;

		void'($urandom(SEED));
		in_rst   = 1'b1;
		in_start = 1'b0;
		in_a     = '0;
		in_b     = '0;
		build_table();

		repeat (RST_CYCLES) @(posedge in_clk);
		#DRIVE_DLY;
		in_rst = 1'b0;

		// quiet idle after reset
		repeat (5) begin
			@(posedge in_clk);
			#SAMPLE_DLY;
			check_done(out_done, 1'b0, "out_done");
			check_prod(out_prod, '0, "out_prod");
		end

		foreach (vec_tab[i]) begin
			v = vec_tab[i];
			run_vec(v, prod_seen, lat_seen);
			check_prod(prod_seen, v.exp_prod, "out_prod");
			check_latency(lat_seen, v.exp_lat, "done latency");
			// done is one cycle, product holds after it
			repeat (HOLD_CYCLES) begin
				@(posedge in_clk);
				#SAMPLE_DLY;
				check_done(out_done, 1'b0, "out_done");
				check_prod(out_prod, v.exp_prod, "out_prod held");
			end
		end

		if (err_cnt == 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			abort_run();
		end
	end

endmodule
